// ==== source/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// architectural register count
`define RV_REG_COUNT 32

// memory depths in 32-bit words
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 256

`endif

// ==== source/rv_pkg.sv ====
package rv_pkg;

  // base opcodes of the supported subset
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } rv_s_fmt_t;

  // branch offset bits as scattered in the word
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } rv_b_fmt_t;

  typedef union packed {
    rv_r_fmt_t r_fmt;
    rv_i_fmt_t i_fmt;
    rv_s_fmt_t s_fmt;
    rv_b_fmt_t b_fmt;
  } rv_inst_u;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
  } rv_alu_op_e;

  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} rv_result_src_e;

  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_B, IMM_J} rv_imm_sel_e;

  typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} rv_fwd_sel_e;

endpackage

// ==== source/rv_regfile.sv ====
`include "rv_cfg.svh"

module rv_regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        we,
  input  logic [31:0] wd,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  logic [31:0] regs [`RV_REG_COUNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_REG_COUNT; i++)
        regs[i] <= '0;
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wd;
    end
  end

  // write-through so decode sees the writeback value
  assign rd1 = (rs1 == 5'd0) ? '0 : (we && rd == rs1) ? wd : regs[rs1];
  assign rd2 = (rs2 == 5'd0) ? '0 : (we && rd == rs2) ? wd : regs[rs2];

endmodule

// ==== source/rv_hazard.sv ====
module rv_hazard import rv_pkg::*; (
  input  logic [4:0]     dec_rs1,
  input  logic [4:0]     dec_rs2,
  input  logic [4:0]     exec_rs1,
  input  logic [4:0]     exec_rs2,
  input  logic [4:0]     exec_rd,
  input  logic [4:0]     mem_rd,
  input  logic [4:0]     wb_rd,
  input  rv_result_src_e exec_result_src,
  input  logic           mem_reg_write,
  input  logic           wb_reg_write,
  input  logic           exec_branch_taken,
  output rv_fwd_sel_e    fwd_a,
  output rv_fwd_sel_e    fwd_b,
  output logic           fetch_stall,
  output logic           decode_stall,
  output logic           decode_flush,
  output logic           exec_flush
);

  logic load_use;

  // memory stage wins over writeback
  always_comb begin
    if (mem_reg_write && mem_rd != 5'd0 && mem_rd == exec_rs1)
      fwd_a = FWD_MEM;
    else if (wb_reg_write && wb_rd != 5'd0 && wb_rd == exec_rs1)
      fwd_a = FWD_WB;
    else
      fwd_a = FWD_REG;

    if (mem_reg_write && mem_rd != 5'd0 && mem_rd == exec_rs2)
      fwd_b = FWD_MEM;
    else if (wb_reg_write && wb_rd != 5'd0 && wb_rd == exec_rs2)
      fwd_b = FWD_WB;
    else
      fwd_b = FWD_REG;
  end

  // load in execute feeding the instruction in decode
  assign load_use = exec_result_src == RES_MEM && exec_rd != 5'd0 &&
                    (exec_rd == dec_rs1 || exec_rd == dec_rs2);

  assign fetch_stall  = load_use;
  assign decode_stall = load_use;
  assign decode_flush = exec_branch_taken;
  assign exec_flush   = load_use || exec_branch_taken;

endmodule

// ==== source/rv_controller.sv ====
module rv_controller import rv_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  rv_inst_u       dec_inst,
  input  logic           exec_equal,
  input  logic           decode_stall,
  input  logic           decode_flush,
  input  logic           exec_flush,
  output rv_imm_sel_e    dec_imm_sel,
  output rv_alu_op_e     exec_alu_op,
  output logic           exec_alu_src,
  output logic           exec_is_branch,
  output logic           exec_branch_ne,
  output logic           exec_is_jal,
  output logic           exec_branch_taken,
  output rv_result_src_e exec_result_src,
  output logic           mem_req,
  output logic           mem_write,
  output logic           mem_reg_write,
  output rv_result_src_e wb_result_src,
  output logic           wb_reg_write
);

  logic           dec_valid;
  logic           d_reg_write, d_mem_req, d_mem_write;
  logic           d_alu_src, d_is_branch, d_branch_ne, d_is_jal;
  rv_alu_op_e     d_alu_op;
  rv_result_src_e d_result_src;
  logic           exec_reg_write, exec_mem_req, exec_mem_write;
  rv_result_src_e mem_result_src;

  // decode slot holds a real instruction unless flushed
  always_ff @(posedge clk) begin
    if (reset || decode_flush)
      dec_valid <= 1'b0;
    else if (!decode_stall)
      dec_valid <= 1'b1;
  end

  always_comb begin
    d_reg_write  = 1'b0;
    d_mem_req    = 1'b0;
    d_mem_write  = 1'b0;
    d_alu_src    = 1'b0;
    d_is_branch  = 1'b0;
    d_branch_ne  = 1'b0;
    d_is_jal     = 1'b0;
    d_alu_op     = ALU_ADD;
    d_result_src = RES_ALU;
    dec_imm_sel  = IMM_I;
    case (dec_inst.r_fmt.opcode)
      OP_REG: begin
        d_reg_write = 1'b1;
        case (dec_inst.r_fmt.funct3)
          3'b000: d_alu_op = dec_inst.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
          3'b010: d_alu_op = ALU_SLT;
          3'b100: d_alu_op = ALU_XOR;
          3'b110: d_alu_op = ALU_OR;
          3'b111: d_alu_op = ALU_AND;
          default: d_reg_write = 1'b0;
        endcase
      end
      OP_IMM: begin
        // addi only
        d_reg_write = dec_inst.i_fmt.funct3 == 3'b000;
        d_alu_src   = 1'b1;
      end
      OP_LOAD: begin
        d_reg_write  = dec_inst.i_fmt.funct3 == 3'b010;
        d_mem_req    = d_reg_write;
        d_alu_src    = 1'b1;
        d_result_src = RES_MEM;
      end
      OP_STORE: begin
        d_mem_req   = dec_inst.s_fmt.funct3 == 3'b010;
        d_mem_write = d_mem_req;
        d_alu_src   = 1'b1;
        dec_imm_sel = IMM_S;
      end
      OP_BRANCH: begin
        d_is_branch = dec_inst.b_fmt.funct3[2:1] == 2'b00;
        d_branch_ne = dec_inst.b_fmt.funct3[0];
        dec_imm_sel = IMM_B;
      end
      OP_JAL: begin
        d_is_jal     = 1'b1;
        d_reg_write  = 1'b1;
        d_result_src = RES_PC4;
        dec_imm_sel  = IMM_J;
      end
      default: ;
    endcase
  end

  // decode to execute
  always_ff @(posedge clk) begin
    if (reset || exec_flush || !dec_valid) begin
      exec_alu_op     <= ALU_ADD;
      exec_alu_src    <= 1'b0;
      exec_is_branch  <= 1'b0;
      exec_branch_ne  <= 1'b0;
      exec_is_jal     <= 1'b0;
      exec_result_src <= RES_ALU;
      exec_reg_write  <= 1'b0;
      exec_mem_req    <= 1'b0;
      exec_mem_write  <= 1'b0;
    end else begin
      exec_alu_op     <= d_alu_op;
      exec_alu_src    <= d_alu_src;
      exec_is_branch  <= d_is_branch;
      exec_branch_ne  <= d_branch_ne;
      exec_is_jal     <= d_is_jal;
      exec_result_src <= d_result_src;
      exec_reg_write  <= d_reg_write;
      exec_mem_req    <= d_mem_req;
      exec_mem_write  <= d_mem_write;
    end
  end

  assign exec_branch_taken = exec_is_jal ||
                             (exec_is_branch && (exec_equal ^ exec_branch_ne));

  // execute to memory, then memory to writeback
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_req        <= 1'b0;
      mem_write      <= 1'b0;
      mem_reg_write  <= 1'b0;
      mem_result_src <= RES_ALU;
      wb_reg_write   <= 1'b0;
      wb_result_src  <= RES_ALU;
    end else begin
      mem_req        <= exec_mem_req;
      mem_write      <= exec_mem_write;
      mem_reg_write  <= exec_reg_write;
      mem_result_src <= exec_result_src;
      wb_reg_write   <= mem_reg_write;
      wb_result_src  <= mem_result_src;
    end
  end

endmodule

// ==== source/rv_datapath.sv ====
`include "rv_cfg.svh"

module rv_datapath import rv_pkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  logic [31:0]    imem_data,
  input  logic [31:0]    read_data,
  input  rv_imm_sel_e    dec_imm_sel,
  input  rv_alu_op_e     exec_alu_op,
  input  logic           exec_alu_src,
  input  logic           exec_is_branch,
  input  logic           exec_branch_ne,
  input  logic           exec_is_jal,
  input  logic           exec_branch_taken,
  input  rv_result_src_e wb_result_src,
  input  logic           wb_reg_write,
  input  rv_fwd_sel_e    fwd_a,
  input  rv_fwd_sel_e    fwd_b,
  input  logic           fetch_stall,
  input  logic           decode_stall,
  input  logic           decode_flush,
  input  logic           exec_flush,
  output logic [31:0]    imem_addr,
  output logic [31:0]    dmem_addr,
  output logic [31:0]    write_data,
  output rv_inst_u       dec_inst,
  output logic [4:0]     dec_rs1,
  output logic [4:0]     dec_rs2,
  output logic [4:0]     exec_rs1,
  output logic [4:0]     exec_rs2,
  output logic [4:0]     exec_rd,
  output logic           exec_equal,
  output logic [4:0]     mem_rd,
  output logic [4:0]     wb_rd
);

  logic [31:0] pc, dec_pc, exec_pc, exec_target;
  logic [31:0] dec_imm, dec_rd1, dec_rd2;
  logic [31:0] exec_imm, exec_rd1, exec_rd2;
  logic [31:0] src_a, src_b, alu_b, alu_out;
  logic [31:0] mem_result, mem_pc4;
  logic [31:0] wb_alu, wb_load, wb_pc4, wb_data;

  // fetch
  always_ff @(posedge clk) begin
    if (reset)
      pc <= `RV_RESET_PC;
    else if (exec_branch_taken)
      pc <= exec_target;
    else if (!fetch_stall)
      pc <= pc + 32'd4;
  end

  assign imem_addr = pc;

  // a zero word in decode acts as a bubble
  always_ff @(posedge clk) begin
    if (reset || decode_flush) begin
      dec_inst <= '0;
      dec_pc   <= '0;
    end else if (!decode_stall) begin
      dec_inst <= imem_data;
      dec_pc   <= pc;
    end
  end

  assign dec_rs1 = dec_inst.r_fmt.rs1;
  assign dec_rs2 = dec_inst.r_fmt.rs2;

  always_comb begin
    case (dec_imm_sel)
      IMM_S:
        dec_imm = {{20{dec_inst.s_fmt.imm_hi[6]}}, dec_inst.s_fmt.imm_hi,
                   dec_inst.s_fmt.imm_lo};
      IMM_B:
        dec_imm = {{20{dec_inst.b_fmt.imm12}}, dec_inst.b_fmt.imm11,
                   dec_inst.b_fmt.imm10_5, dec_inst.b_fmt.imm4_1, 1'b0};
      // jal offset reuses the i view fields
      IMM_J:
        dec_imm = {{12{dec_inst.i_fmt.imm12[11]}}, dec_inst.i_fmt.rs1,
                   dec_inst.i_fmt.funct3, dec_inst.i_fmt.imm12[0],
                   dec_inst.i_fmt.imm12[10:1], 1'b0};
      default:
        dec_imm = {{20{dec_inst.i_fmt.imm12[11]}}, dec_inst.i_fmt.imm12};
    endcase
  end

  rv_regfile u_regfile (
    .clk(clk), .reset(reset),
    .rs1(dec_rs1), .rs2(dec_rs2),
    .rd(wb_rd), .we(wb_reg_write), .wd(wb_data),
    .rd1(dec_rd1), .rd2(dec_rd2)
  );

  // decode to execute
  always_ff @(posedge clk) begin
    if (reset || exec_flush) begin
      exec_rs1 <= '0;
      exec_rs2 <= '0;
      exec_rd  <= '0;
    end else begin
      exec_rs1 <= dec_rs1;
      exec_rs2 <= dec_rs2;
      exec_rd  <= dec_inst.r_fmt.rd;
    end
  end

  always_ff @(posedge clk) begin
    exec_pc  <= dec_pc;
    exec_imm <= dec_imm;
    exec_rd1 <= dec_rd1;
    exec_rd2 <= dec_rd2;
  end

  // execute operand selection
  always_comb begin
    case (fwd_a)
      FWD_MEM: src_a = mem_result;
      FWD_WB:  src_a = wb_data;
      default: src_a = exec_rd1;
    endcase
    case (fwd_b)
      FWD_MEM: src_b = mem_result;
      FWD_WB:  src_b = wb_data;
      default: src_b = exec_rd2;
    endcase
  end

  assign alu_b       = exec_alu_src ? exec_imm : src_b;
  assign exec_equal  = src_a == src_b;
  assign exec_target = exec_pc + exec_imm;

  always_comb begin
    case (exec_alu_op)
      ALU_SUB: alu_out = src_a - alu_b;
      ALU_AND: alu_out = src_a & alu_b;
      ALU_OR:  alu_out = src_a | alu_b;
      ALU_XOR: alu_out = src_a ^ alu_b;
      ALU_SLT: alu_out = {31'd0, $signed(src_a) < $signed(alu_b)};
      default: alu_out = src_a + alu_b;
    endcase
  end

  // execute to memory
  always_ff @(posedge clk) begin
    if (reset)
      mem_rd <= '0;
    else
      mem_rd <= exec_rd;
  end

  // jal carries its link value as the result
  always_ff @(posedge clk) begin
    mem_result <= exec_is_jal ? exec_pc + 32'd4 : alu_out;
    mem_pc4    <= exec_pc + 32'd4;
    write_data <= src_b;
  end

  assign dmem_addr = mem_result;

  // memory to writeback
  always_ff @(posedge clk) begin
    if (reset)
      wb_rd <= '0;
    else
      wb_rd <= mem_rd;
  end

  always_ff @(posedge clk) begin
    wb_alu  <= mem_result;
    wb_load <= read_data;
    wb_pc4  <= mem_pc4;
  end

  always_comb begin
    case (wb_result_src)
      RES_MEM: wb_data = wb_load;
      RES_PC4: wb_data = wb_pc4;
      default: wb_data = wb_alu;
    endcase
  end

endmodule

// ==== source/rv_top.sv ====
module rv_top import rv_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_data,
  output logic [31:0] dmem_addr,
  output logic [31:0] write_data,
  input  logic [31:0] read_data,
  output logic        mem_req,
  output logic        mem_write
);

  // from datapath
  rv_inst_u       dec_inst;
  logic           exec_equal;
  logic [4:0]     dec_rs1, dec_rs2;
  logic [4:0]     exec_rs1, exec_rs2, exec_rd;
  logic [4:0]     mem_rd, wb_rd;

  // from controller
  rv_imm_sel_e    dec_imm_sel;
  rv_alu_op_e     exec_alu_op;
  logic           exec_alu_src;
  logic           exec_is_branch, exec_branch_ne, exec_is_jal;
  logic           exec_branch_taken;
  rv_result_src_e exec_result_src, wb_result_src;
  logic           mem_reg_write, wb_reg_write;

  // from hazard unit
  rv_fwd_sel_e    fwd_a, fwd_b;
  logic           fetch_stall, decode_stall, decode_flush, exec_flush;

  rv_datapath u_datapath (
    .clk(clk), .reset(reset),
    .imem_data(imem_data), .read_data(read_data),
    .dec_imm_sel(dec_imm_sel),
    .exec_alu_op(exec_alu_op), .exec_alu_src(exec_alu_src),
    .exec_is_branch(exec_is_branch), .exec_branch_ne(exec_branch_ne),
    .exec_is_jal(exec_is_jal), .exec_branch_taken(exec_branch_taken),
    .wb_result_src(wb_result_src), .wb_reg_write(wb_reg_write),
    .fwd_a(fwd_a), .fwd_b(fwd_b),
    .fetch_stall(fetch_stall), .decode_stall(decode_stall),
    .decode_flush(decode_flush), .exec_flush(exec_flush),
    .imem_addr(imem_addr), .dmem_addr(dmem_addr), .write_data(write_data),
    .dec_inst(dec_inst), .exec_equal(exec_equal),
    .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
    .exec_rs1(exec_rs1), .exec_rs2(exec_rs2), .exec_rd(exec_rd),
    .mem_rd(mem_rd), .wb_rd(wb_rd)
  );

  rv_controller u_controller (
    .clk(clk), .reset(reset),
    .dec_inst(dec_inst), .exec_equal(exec_equal),
    .decode_stall(decode_stall), .decode_flush(decode_flush),
    .exec_flush(exec_flush),
    .dec_imm_sel(dec_imm_sel),
    .exec_alu_op(exec_alu_op), .exec_alu_src(exec_alu_src),
    .exec_is_branch(exec_is_branch), .exec_branch_ne(exec_branch_ne),
    .exec_is_jal(exec_is_jal), .exec_branch_taken(exec_branch_taken),
    .exec_result_src(exec_result_src),
    .mem_req(mem_req), .mem_write(mem_write), .mem_reg_write(mem_reg_write),
    .wb_result_src(wb_result_src), .wb_reg_write(wb_reg_write)
  );

  rv_hazard u_hazard (
    .dec_rs1(dec_rs1), .dec_rs2(dec_rs2),
    .exec_rs1(exec_rs1), .exec_rs2(exec_rs2), .exec_rd(exec_rd),
    .mem_rd(mem_rd), .wb_rd(wb_rd),
    .exec_result_src(exec_result_src),
    .mem_reg_write(mem_reg_write), .wb_reg_write(wb_reg_write),
    .exec_branch_taken(exec_branch_taken),
    .fwd_a(fwd_a), .fwd_b(fwd_b),
    .fetch_stall(fetch_stall), .decode_stall(decode_stall),
    .decode_flush(decode_flush), .exec_flush(exec_flush)
  );

endmodule

// ==== dv/rv_tb_model.svh ====
`ifndef RV_TB_MODEL_SVH
`define RV_TB_MODEL_SVH

localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
localparam logic [6:0]  OPC_REG    = 7'b0110011;
localparam logic [6:0]  OPC_IMM    = 7'b0010011;
localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
localparam logic [6:0]  OPC_STORE  = 7'b0100011;
localparam logic [6:0]  OPC_BRANCH = 7'b1100011;
localparam logic [6:0]  OPC_JAL    = 7'b1101111;
localparam int          IMEM_AW    = $clog2(`RV_IMEM_WORDS);
localparam int          DMEM_AW    = $clog2(`RV_DMEM_WORDS);

logic [31:0] lfsr_state;
logic [31:0] mregs [32];
logic [31:0] mdmem [`RV_DMEM_WORDS];
logic [31:0] exp_addr [$];
logic [31:0] exp_data [$];
logic [31:0] halt_pc;
int          model_steps;

// galois lfsr stepped once per bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_state[0]};
    lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
  end
  return v;
endfunction

// initial data memory word built from its whole index
function automatic logic [31:0] fill_word(input int idx);
  logic [7:0] a;
  a = 8'(idx);
  return {a, ~a, a ^ 8'h5a, a + 8'd1};
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OPC_REG};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

function automatic logic [31:0] random_alu_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
  logic [2:0] sel;
  sel = 3'(rand_bits(3));
  case (sel)
    3'd0:    return enc_r(7'h00, rs2, rs1, 3'b000, rd);
    3'd1:    return enc_r(7'h20, rs2, rs1, 3'b000, rd);
    3'd2:    return enc_r(7'h00, rs2, rs1, 3'b111, rd);
    3'd3:    return enc_r(7'h00, rs2, rs1, 3'b110, rd);
    3'd4:    return enc_r(7'h00, rs2, rs1, 3'b100, rd);
    default: return enc_r(7'h00, rs2, rs1, 3'b010, rd);
  endcase
endfunction

// registers drawn from x0..x7 so hazards are frequent
function automatic void gen_program();
  int         body;
  int         t;
  logic [2:0] kind;
  logic [4:0] rd, rs1, rs2;
  logic [11:0] off;
  lfsr_state = 32'h447f_1f41;
  for (int i = 0; i < `RV_IMEM_WORDS; i++)
    imem[i] = '0;
  body = 40 + int'(rand_bits(4));
  for (int i = 0; i < body; i++) begin
    kind = 3'(rand_bits(3));
    rd   = 5'(rand_bits(3));
    rs1  = 5'(rand_bits(3));
    rs2  = 5'(rand_bits(3));
    off  = 12'(rand_bits(5) * 4);
    // forward target that stops at the final store block
    t    = i + 1 + int'(rand_bits(2));
    if (t > body)
      t = body;
    case (kind)
      3'd3:    imem[i] = enc_i(12'(rand_bits(12)), rs1, 3'b000, rd, OPC_IMM);
      3'd4:    imem[i] = enc_i(off, 5'd0, 3'b010, rd, OPC_LOAD);
      3'd5:    imem[i] = enc_s(off, rs2, 5'd0);
      3'd6:    imem[i] = enc_b(13'((t - i) * 4), rs2, rs1, {2'b00, 1'(rand_bits(1))});
      3'd7:    imem[i] = enc_j(21'((t - i) * 4), rd);
      default: imem[i] = random_alu_inst(rd, rs1, rs2);
    endcase
  end
  // dump every register and then spin in place
  for (int r = 0; r < 32; r++)
    imem[body + r] = enc_s(12'(r * 4), 5'(r), 5'd0);
  imem[body + 32] = enc_j(21'd0, 5'd0);
  halt_pc = 32'((body + 32) * 4);
endfunction

function automatic void run_model();
  logic [31:0] pc, inst, a, b, wval, next_pc, addr;
  logic [31:0] imm_i, imm_s, imm_b, imm_j;
  logic [4:0]  rd;
  logic        wen;
  pc = `RV_RESET_PC;
  model_steps = 0;
  for (int r = 0; r < 32; r++)
    mregs[r] = '0;
  for (int w = 0; w < `RV_DMEM_WORDS; w++)
    mdmem[w] = fill_word(w);
  while (pc != halt_pc) begin
    inst    = imem[pc[IMEM_AW+1:2]];
    rd      = inst[11:7];
    a       = mregs[inst[19:15]];
    b       = mregs[inst[24:20]];
    imm_i   = {{20{inst[31]}}, inst[31:20]};
    imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j   = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    next_pc = pc + 32'd4;
    wen     = 1'b0;
    wval    = '0;
    case (inst[6:0])
      OPC_REG: begin
        wen = 1'b1;
        case (inst[14:12])
          3'b000:  wval = inst[30] ? a - b : a + b;
          3'b010:  wval = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'b100:  wval = a ^ b;
          3'b110:  wval = a | b;
          default: wval = a & b;
        endcase
      end
      OPC_IMM: begin
        wen  = 1'b1;
        wval = a + imm_i;
      end
      OPC_LOAD: begin
        wen  = 1'b1;
        addr = a + imm_i;
        wval = mdmem[addr[DMEM_AW+1:2]];
      end
      OPC_STORE: begin
        addr = a + imm_s;
        mdmem[addr[DMEM_AW+1:2]] = b;
        exp_addr.push_back(addr);
        exp_data.push_back(b);
      end
      OPC_BRANCH: begin
        if ((a == b) != inst[12])
          next_pc = pc + imm_b;
      end
      OPC_JAL: begin
        wen     = 1'b1;
        wval    = pc + 32'd4;
        next_pc = pc + imm_j;
      end
      default: ;
    endcase
    if (wen && rd != 5'd0)
      mregs[rd] = wval;
    pc = next_pc;
    model_steps++;
  end
endfunction

`endif

// ==== dv/rv_tb.sv ====
`include "rv_cfg.svh"

module rv_tb;

  logic        clk;
  logic        reset;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] write_data;
  logic [31:0] read_data;
  logic        mem_req;
  logic        mem_write;

  logic [31:0] imem [`RV_IMEM_WORDS];
  logic [31:0] dmem [`RV_DMEM_WORDS];
  int          limit_cycles;

  `include "rv_tb_model.svh"

  rv_top rv_top_inst (
    .clk(clk),
    .reset(reset),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .dmem_addr(dmem_addr),
    .write_data(write_data),
    .read_data(read_data),
    .mem_req(mem_req),
    .mem_write(mem_write)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // both memories read combinationally
  assign imem_data = imem[imem_addr[IMEM_AW+1:2]];
  assign read_data = dmem[dmem_addr[DMEM_AW+1:2]];

  // data memory is refilled while reset is high
  always @(posedge clk) begin
    if (reset) begin
      for (int w = 0; w < `RV_DMEM_WORDS; w++)
        dmem[w] <= fill_word(w);
    end else if (mem_req && mem_write) begin
      dmem[dmem_addr[DMEM_AW+1:2]] <= write_data;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("Fail %s: got 0x%08h expected 0x%08h", name, got, expected);
      $display("Checks failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // each store in the memory stage must be the next one the model made
  task automatic check_stores();
    int seen;
    seen = 0;
    while (seen < exp_addr.size()) begin
      @(negedge clk);
      if (mem_req && mem_write) begin
        check_value("dmem_addr", dmem_addr, exp_addr[seen]);
        check_value("write_data", write_data, exp_data[seen]);
        seen++;
      end
    end
  endtask

  initial begin
    reset        = 1'b1;
    limit_cycles = 0;
    gen_program();
    run_model();
    limit_cycles = model_steps * 8 + 100;
    // pc stays at the reset address with no memory traffic
    repeat (8) begin
      @(negedge clk);
      check_value("imem_addr", imem_addr, `RV_RESET_PC);
      check_value("mem_req", 32'(mem_req), 32'd0);
      check_value("mem_write", 32'(mem_write), 32'd0);
    end
    reset = 1'b0;
    check_stores();
    $display("All checks passed");
    $finish;
  end

  // watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Checks failed");
    $fatal(1, "timeout, the expected stores did not all appear within %0d cycles",
           limit_cycles);
  end

endmodule

// ==== sim.f ====
+incdir+source
+incdir+dv
source/rv_pkg.sv
source/rv_regfile.sv
source/rv_hazard.sv
source/rv_controller.sv
source/rv_datapath.sv
source/rv_top.sv
dv/rv_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_tb
RTL_TOP   ?= rv_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
SEED_ARGS ?= +verilator+seed+7
LINT_ARGS ?= -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_ARGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard source/*.sv source/*.svh dv/*.sv dv/*.svh)
	$(VERILATOR) --binary -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(OBJ_DIR)
